// ==== hdl/sdram_pkg.sv ====
package sdram_pkg;

	// word address split, row on top and column at the bottom
	localparam int ROW_W  = 13;
	localparam int BANK_W = 2;
	localparam int COL_W  = 9;
	localparam int ADDR_W = ROW_W + BANK_W + COL_W;
	localparam int DATA_W = 32;

	// minimum cycles from a command to the next one
	localparam int T_RCD   = 2;
	localparam int T_RP    = 2;
	localparam int T_RFC   = 8;
	localparam int T_WR    = 2;
	localparam int CAS_LAT = 2;

	localparam int REFRESH_PERIOD = 390;
	localparam int IDLE_CLOSE     = 4; // idle cycles before an open page is closed

	localparam int WAIT_W       = $clog2(T_RFC); // holds the longest wait minus one
	localparam int REFRESH_W    = $clog2(REFRESH_PERIOD);
	localparam int IDLE_W       = $clog2(IDLE_CLOSE + 1);
	localparam int PRCH_ALL_BIT = 10; // A10 high closes all banks

	// {ras_n, cas_n, we_n} as seen on the pins
	typedef enum logic [2:0] {
		NOOP = 3'b111,
		ACTV = 3'b011,
		READ = 3'b101,
		WRTE = 3'b100,
		PRCH = 3'b010,
		ARSR = 3'b001
	} sdram_cmd_e;

	typedef struct packed {
		logic [ROW_W-1:0]  row;
		logic [BANK_W-1:0] bank;
		logic [COL_W-1:0]  col;
	} sdram_addr_fields_s;

	typedef union packed {
		logic [ADDR_W-1:0]  flat; // as it arrives from the bus
		sdram_addr_fields_s fld;  // as the SDRAM sees it
	} sdram_addr_u;

	typedef struct packed {
		logic              valid;
		logic              we;
		sdram_addr_u       addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_s;

	typedef struct packed {
		sdram_cmd_e        cmd;
		logic [BANK_W-1:0] bank;
		logic [ROW_W-1:0]  addr;
		logic [DATA_W-1:0] wdata;
	} sdram_cmd_s;

endpackage

// ==== hdl/wb_request_port.sv ====
`timescale 1ns/1ps

module wb_request_port (
	input  logic                          CLK,
	input  logic                          RST,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [sdram_pkg::ADDR_W-1:0]  wb_adr,
	input  logic [sdram_pkg::DATA_W-1:0]  wb_dat_w,
	output logic                          wb_ack,
	output logic [sdram_pkg::DATA_W-1:0]  wb_dat_r,
	output sdram_pkg::mem_req_s           req,
	input  logic                          req_done,
	input  logic                          rd_valid,
	input  logic [sdram_pkg::DATA_W-1:0]  rd_data
);

	logic rd_pending; // read command sent, data not yet back
	logic take;

	// a new access is only taken once the previous one has been acked
	assign take = wb_cyc && wb_stb && !req.valid && !rd_pending && !wb_ack;

	always_ff @(posedge CLK)
		if (!RST)
		begin
			req.valid  <= 1'b0;
			rd_pending <= 1'b0;
			wb_ack     <= 1'b0;
		end
		else
		begin
			wb_ack <= 1'b0; // single cycle pulse
			if (take)
			begin
				req.valid     <= 1'b1;
				req.we        <= wb_we;
				req.addr.flat <= wb_adr;
				req.wdata     <= wb_dat_w;
			end
			else if (req_done)
			begin
				req.valid  <= 1'b0;
				rd_pending <= !req.we;
				wb_ack     <= req.we; // writes are done once latched
			end

			if (rd_pending && rd_valid)
			begin
				rd_pending <= 1'b0;
				wb_ack     <= 1'b1;
				wb_dat_r   <= rd_data;
			end
		end

endmodule

// ==== hdl/page_tracker.sv ====
`timescale 1ns/1ps

module page_tracker (
	input  logic                   CLK,
	input  logic                   RST,
	input  sdram_pkg::mem_req_s    req,
	input  logic                   issue_ok,
	input  logic                   refresh_due,
	output sdram_pkg::sdram_cmd_e  cmd_wanted,
	output sdram_pkg::sdram_cmd_s  cmd_next,
	output logic                   req_done
);

	import sdram_pkg::*;

	logic              page_open;
	logic [ROW_W-1:0]  open_row;
	logic [BANK_W-1:0] open_bank;
	logic [IDLE_W-1:0] idle_cnt;
	logic              hit;
	logic              idle_expired;
	logic              latched;

	assign hit = page_open && (req.addr.fld.row == open_row) &&
		(req.addr.fld.bank == open_bank);
	assign idle_expired = (idle_cnt == IDLE_W'(IDLE_CLOSE));

	always_comb
	begin
		if (refresh_due)
			cmd_wanted = page_open ? PRCH : ARSR; // refresh needs all banks idle
		else if (req.valid && hit)
			cmd_wanted = req.we ? WRTE : READ;
		else if (req.valid && page_open)
			cmd_wanted = PRCH; // wrong page
		else if (req.valid)
			cmd_wanted = ACTV;
		else if (page_open && idle_expired)
			cmd_wanted = PRCH;
		else
			cmd_wanted = NOOP;
	end

	assign latched  = issue_ok && (cmd_wanted != NOOP);
	assign req_done = latched && ((cmd_wanted == READ) || (cmd_wanted == WRTE));

	always_comb
	begin
		cmd_next.cmd   = latched ? cmd_wanted : NOOP;
		cmd_next.bank  = (cmd_wanted == PRCH) ? open_bank : req.addr.fld.bank;
		cmd_next.addr  = '0;
		cmd_next.wdata = req.wdata;
		case (cmd_wanted)
			ACTV:       cmd_next.addr = req.addr.fld.row;
			READ, WRTE: cmd_next.addr = ROW_W'(req.addr.fld.col); // A10 low, no auto precharge
			PRCH:       cmd_next.addr[PRCH_ALL_BIT] = 1'b1;
			default:    cmd_next.addr = '0;
		endcase
	end

	always_ff @(posedge CLK)
		if (!RST)
		begin
			page_open <= 1'b0;
			idle_cnt  <= '0;
		end
		else
		begin
			if (latched && (cmd_wanted == ACTV))
				page_open <= 1'b1;
			if (latched && (cmd_wanted == PRCH))
				page_open <= 1'b0;

			if (req.valid || latched)
				idle_cnt <= '0;
			else if (page_open && !idle_expired)
				idle_cnt <= idle_cnt + 1'b1;
		end

	always_ff @(posedge CLK)
		if (latched && (cmd_wanted == ACTV))
		begin
			open_row  <= req.addr.fld.row;
			open_bank <= req.addr.fld.bank;
		end

endmodule

// ==== hdl/command_timer.sv ====
`timescale 1ns/1ps

module command_timer (
	input  logic                   CLK,
	input  logic                   RST,
	input  sdram_pkg::sdram_cmd_e  cmd_wanted,
	input  sdram_pkg::sdram_cmd_s  cmd_next,
	output logic                   issue_ok,
	output logic                   refresh_due
);

	import sdram_pkg::*;

	logic [WAIT_W-1:0]    wait_cnt;
	logic [WAIT_W-1:0]    wait_load;
	logic [REFRESH_W-1:0] refresh_cnt;
	logic                 latched;

	assign latched = issue_ok && (cmd_wanted != NOOP);

	// issue_ok stays low for the full wait of the latched command
	always_comb
		case (cmd_next.cmd)
			ACTV:    wait_load = WAIT_W'(T_RCD - 1);
			PRCH:    wait_load = WAIT_W'(T_RP - 1);
			ARSR:    wait_load = WAIT_W'(T_RFC - 1);
			WRTE:    wait_load = WAIT_W'(T_WR - 1);
			READ:    wait_load = WAIT_W'(CAS_LAT - 1);
			default: wait_load = '0;
		endcase

	always_ff @(posedge CLK)
		if (!RST)
		begin
			issue_ok <= 1'b0;
			wait_cnt <= '0;
		end
		else if (latched)
		begin
			issue_ok <= 1'b0;
			wait_cnt <= wait_load;
		end
		else if (wait_cnt != '0)
			wait_cnt <= wait_cnt - 1'b1;
		else
			issue_ok <= 1'b1;

	// free running refresh interval
	always_ff @(posedge CLK)
		if (!RST)
		begin
			refresh_cnt <= '0;
			refresh_due <= 1'b0;
		end
		else
		begin
			if (latched && (cmd_next.cmd == ARSR))
				refresh_due <= 1'b0;

			if (refresh_cnt == REFRESH_W'(REFRESH_PERIOD - 1))
			begin
				refresh_cnt <= '0;
				refresh_due <= 1'b1; // a new expiry wins over a clear
			end
			else
				refresh_cnt <= refresh_cnt + 1'b1;
		end

endmodule

// ==== hdl/sdram_pins.sv ====
`timescale 1ns/1ps

module sdram_pins (
	input  logic                          CLK,
	input  logic                          RST,
	input  sdram_pkg::sdram_cmd_s         cmd_next,
	output sdram_pkg::sdram_cmd_e         sdram_cmd,
	output logic [sdram_pkg::BANK_W-1:0]  sdram_ba,
	output logic [sdram_pkg::ROW_W-1:0]   sdram_a,
	output logic [sdram_pkg::DATA_W-1:0]  dq_out,
	output logic                          dq_oe,
	input  logic [sdram_pkg::DATA_W-1:0]  dq_in,
	output logic                          rd_valid,
	output logic [sdram_pkg::DATA_W-1:0]  rd_data
);

	import sdram_pkg::*;

	// one marker per read in flight, stage 0 is the cycle READ is on the pins
	logic [CAS_LAT-1:0] rd_mark;

	always_ff @(posedge CLK)
		if (!RST)
		begin
			sdram_cmd <= NOOP;
			dq_oe     <= 1'b0;
			rd_mark   <= '0;
			rd_valid  <= 1'b0;
		end
		else
		begin
			sdram_cmd <= cmd_next.cmd;
			dq_oe     <= (cmd_next.cmd == WRTE); // data goes out with the command
			rd_mark   <= {rd_mark[CAS_LAT-2:0], (cmd_next.cmd == READ)};
			rd_valid  <= rd_mark[CAS_LAT-1];
		end

	always_ff @(posedge CLK)
	begin
		sdram_ba <= cmd_next.bank;
		sdram_a  <= cmd_next.addr;
		dq_out   <= cmd_next.wdata;
		if (rd_mark[CAS_LAT-1])
			rd_data <= dq_in; // dq_in valid in the last marker cycle
	end

endmodule

// ==== hdl/sdram_ctrl_top.sv ====
`timescale 1ns/1ps

module sdram_ctrl_top (
	input  logic                          CLK,
	input  logic                          RST,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [sdram_pkg::ADDR_W-1:0]  wb_adr,
	input  logic [sdram_pkg::DATA_W-1:0]  wb_dat_w,
	output logic                          wb_ack,
	output logic [sdram_pkg::DATA_W-1:0]  wb_dat_r,
	output sdram_pkg::sdram_cmd_e         sdram_cmd,
	output logic [sdram_pkg::BANK_W-1:0]  sdram_ba,
	output logic [sdram_pkg::ROW_W-1:0]   sdram_a,
	output logic [sdram_pkg::DATA_W-1:0]  dq_out,
	output logic                          dq_oe,
	input  logic [sdram_pkg::DATA_W-1:0]  dq_in
);

	import sdram_pkg::*;

	mem_req_s          req;
	logic              req_done;
	logic              rd_valid;
	logic [DATA_W-1:0] rd_data;
	sdram_cmd_e        cmd_wanted;
	sdram_cmd_s        cmd_next;
	logic              issue_ok;
	logic              refresh_due;

	wb_request_port wb_port_i (
		.CLK      (CLK),
		.RST      (RST),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_ack   (wb_ack),
		.wb_dat_r (wb_dat_r),
		.req      (req),
		.req_done (req_done),
		.rd_valid (rd_valid),
		.rd_data  (rd_data)
	);

	page_tracker page_i (
		.CLK         (CLK),
		.RST         (RST),
		.req         (req),
		.issue_ok    (issue_ok),
		.refresh_due (refresh_due),
		.cmd_wanted  (cmd_wanted),
		.cmd_next    (cmd_next),
		.req_done    (req_done)
	);

	command_timer timer_i (
		.CLK         (CLK),
		.RST         (RST),
		.cmd_wanted  (cmd_wanted),
		.cmd_next    (cmd_next),
		.issue_ok    (issue_ok),
		.refresh_due (refresh_due)
	);

	sdram_pins pins_i (
		.CLK       (CLK),
		.RST       (RST),
		.cmd_next  (cmd_next),
		.sdram_cmd (sdram_cmd),
		.sdram_ba  (sdram_ba),
		.sdram_a   (sdram_a),
		.dq_out    (dq_out),
		.dq_oe     (dq_oe),
		.dq_in     (dq_in),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

endmodule

// ==== tests/sdram_ctrl_properties.sv ====
`timescale 1ns/1ps

module sdram_ctrl_properties (
	input logic                  CLK,
	input logic                  RST,
	input logic                  wb_cyc,
	input logic                  wb_stb,
	input logic                  wb_ack,
	input sdram_pkg::sdram_cmd_e sdram_cmd
);

	import sdram_pkg::*;

	ack_in_cycle: assert property (@(posedge CLK) disable iff (!RST)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("wb_ack asserted without wb_cyc and wb_stb");

	ack_one_cycle: assert property (@(posedge CLK) disable iff (!RST) wb_ack |=> !wb_ack)
		else $error("wb_ack held for more than one cycle");

	// NOOP cycles on the pins after each command
	actv_gap: assert property (@(posedge CLK) disable iff (!RST)
		(sdram_cmd == ACTV) |=> (sdram_cmd == NOOP) [*T_RCD])
		else $error("command issued within T_RCD of ACTV");

	prch_gap: assert property (@(posedge CLK) disable iff (!RST)
		(sdram_cmd == PRCH) |=> (sdram_cmd == NOOP) [*T_RP])
		else $error("command issued within T_RP of PRCH");

	arsr_gap: assert property (@(posedge CLK) disable iff (!RST)
		(sdram_cmd == ARSR) |=> (sdram_cmd == NOOP) [*T_RFC])
		else $error("command issued within T_RFC of ARSR");

	wrte_gap: assert property (@(posedge CLK) disable iff (!RST)
		(sdram_cmd == WRTE) |=> (sdram_cmd == NOOP) [*T_WR])
		else $error("command issued within T_WR of WRTE");

	read_gap: assert property (@(posedge CLK) disable iff (!RST)
		(sdram_cmd == READ) |=> (sdram_cmd == NOOP) [*CAS_LAT])
		else $error("command issued within CAS_LAT of READ");

endmodule

// ==== tests/tb_sdram_ctrl.sv ====
`timescale 1ns/1ps

module tb_sdram_ctrl;

	import sdram_pkg::*;

	localparam int CLK_PERIOD    = 8;
	localparam int RESET_CYCLES  = 16;
	localparam int NUM_ACC       = 400;
	localparam int TIMEOUT_NS    = NUM_ACC * 40 * CLK_PERIOD;
	localparam int REFRESH_LIMIT = REFRESH_PERIOD + T_RFC + 20;
	localparam logic [DATA_W-1:0] IDLE_WORD = 32'hdead_beef; // dq_in when no read is due

	logic              CLK;
	logic              RST;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	logic [ADDR_W-1:0] wb_adr;
	logic [DATA_W-1:0] wb_dat_w;
	logic              wb_ack;
	logic [DATA_W-1:0] wb_dat_r;
	sdram_cmd_e        sdram_cmd;
	logic [BANK_W-1:0] sdram_ba;
	logic [ROW_W-1:0]  sdram_a;
	logic [DATA_W-1:0] dq_out;
	logic              dq_oe;
	logic [DATA_W-1:0] dq_in;

	integer     seed = 91;
	int         mismatch_errors = 0;
	int         sdram_errors = 0;
	int         bus_errors = 0;
	int         ack_count = 0;
	int         cycle_cnt = 0;
	int         last_arsr = 0;
	sdram_cmd_e last_cmd = NOOP;
	int         noop_run = 0;

	logic [DATA_W-1:0]          ref_mem [logic [ADDR_W-1:0]];   // expected contents
	logic [DATA_W-1:0]          sdram_mem [logic [ADDR_W-1:0]]; // SDRAM model array
	logic [(1<<BANK_W)-1:0]     bank_open;
	logic [ROW_W-1:0]           bank_row [1<<BANK_W];
	logic [DATA_W-1:0]          rd_pipe [CAS_LAT-1]; // words on their way to dq_in

	sdram_ctrl_top dut_i (.*);

	bind sdram_ctrl_top sdram_ctrl_properties props_i (
		.CLK       (CLK),
		.RST       (RST),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_ack    (wb_ack),
		.sdram_cmd (sdram_cmd)
	);

	initial
	begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// small row set so hits, misses and bank changes all show up
	function automatic logic [ROW_W-1:0] pick_row(input logic [1:0] idx);
		case (idx)
			2'd0:    pick_row = 13'h0000;
			2'd1:    pick_row = 13'h0a31;
			2'd2:    pick_row = 13'h1fff;
			default: pick_row = 13'h0404;
		endcase
	endfunction

	// NOOP cycles each command needs before the next one
	function automatic int required_gap(input sdram_cmd_e cmd);
		case (cmd)
			ACTV:    required_gap = T_RCD;
			PRCH:    required_gap = T_RP;
			ARSR:    required_gap = T_RFC;
			WRTE:    required_gap = T_WR;
			READ:    required_gap = CAS_LAT;
			default: required_gap = 0;
		endcase
	endfunction

	task automatic bus_idle(input int cycles);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		repeat (cycles) @(negedge CLK);
	endtask

	task automatic wb_access(input logic we, input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] dat);
		logic [DATA_W-1:0] expected;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		do
			@(negedge CLK);
		while (!wb_ack);
		if (we)
			ref_mem[adr] = dat;
		else
		begin
			expected = ref_mem.exists(adr) ? ref_mem[adr] : '0; // never written reads zero
			if (wb_dat_r !== expected)
			begin
				mismatch_errors++;
				$display("Mismatch wb_dat_r at address %h: got %h expected %h",
					adr, wb_dat_r, expected);
			end
		end
		@(negedge CLK); // stb held through the edge that samples ack
	endtask

	always @(posedge CLK)
		if (RST)
			cycle_cnt++;

	// behavioral SDRAM that looks at the pins in the middle of each cycle
	always @(negedge CLK)
	begin : sdram_model
		logic [ADDR_W-1:0] loc;
		dq_in = rd_pipe[CAS_LAT-2];
		for (int i = CAS_LAT - 2; i > 0; i--)
			rd_pipe[i] = rd_pipe[i-1];
		rd_pipe[0] = IDLE_WORD;
		loc = {bank_row[sdram_ba], sdram_ba, sdram_a[COL_W-1:0]};
		if (dq_oe && (sdram_cmd != WRTE))
		begin
			sdram_errors++;
			$display("ERROR: dq_oe high without a write command");
		end
		if (sdram_cmd != NOOP)
		begin
			if (noop_run < required_gap(last_cmd))
			begin
				sdram_errors++;
				$display("ERROR: %s after only %0d idle cycles following %s",
					sdram_cmd.name(), noop_run, last_cmd.name());
			end
			last_cmd = sdram_cmd;
			noop_run = 0;
		end
		else
			noop_run++;
		case (sdram_cmd)
			ACTV:
			begin
				if (bank_open[sdram_ba])
				begin
					sdram_errors++;
					$display("ERROR: ACTV to bank %0d while row %h is still open",
						sdram_ba, bank_row[sdram_ba]);
				end
				bank_open[sdram_ba] = 1'b1;
				bank_row[sdram_ba]  = sdram_a;
			end
			PRCH:
				if (sdram_a[PRCH_ALL_BIT])
					bank_open = '0;
				else
					bank_open[sdram_ba] = 1'b0;
			READ, WRTE:
			begin
				if (!bank_open[sdram_ba])
				begin
					sdram_errors++;
					$display("ERROR: %s to bank %0d with no open row", sdram_cmd.name(), sdram_ba);
				end
				if (sdram_cmd == READ)
					rd_pipe[0] = sdram_mem.exists(loc) ? sdram_mem[loc] : '0;
				else if (!dq_oe)
				begin
					sdram_errors++;
					$display("ERROR: write command without dq_oe");
				end
				else
					sdram_mem[loc] = dq_out;
			end
			ARSR:
			begin
				if (bank_open != '0)
				begin
					sdram_errors++;
					$display("ERROR: refresh issued with banks %b still open", bank_open);
				end
				if (cycle_cnt - last_arsr > REFRESH_LIMIT)
				begin
					sdram_errors++;
					$display("ERROR: %0d cycles between refreshes", cycle_cnt - last_arsr);
				end
				last_arsr = cycle_cnt;
			end
			default: ;
		endcase
	end

	always @(posedge CLK)
		if (RST && wb_ack)
		begin
			ack_count++;
			if (!(wb_cyc && wb_stb))
			begin
				bus_errors++;
				$display("ERROR: wb_ack high with no active cycle and strobe");
			end
		end

	initial
	begin : watchdog
		#(TIMEOUT_NS);
		$display("ERROR: run timed out after %0d ns, %0d of %0d accesses acked",
			TIMEOUT_NS, ack_count, NUM_ACC);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin : stimulus
		logic [31:0]       r;
		logic [ROW_W-1:0]  row;
		logic [BANK_W-1:0] bank;
		logic [COL_W-1:0]  col;
		RST       = 1'b0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		dq_in     = IDLE_WORD;
		bank_open = '0;
		foreach (rd_pipe[i])
			rd_pipe[i] = IDLE_WORD;

		repeat (RESET_CYCLES)
		begin
			@(negedge CLK);
			if ((sdram_cmd !== NOOP) || (dq_oe !== 1'b0) || (wb_ack !== 1'b0))
			begin
				mismatch_errors++;
				$display("Mismatch sdram_cmd/dq_oe/wb_ack in reset: got %h/%h/%h expected %h/0/0",
					sdram_cmd, dq_oe, wb_ack, NOOP);
			end
		end
		RST = 1'b1;

		for (int n = 0; n < NUM_ACC; n++)
		begin
			r = $random(seed);
			if ((n == 0) || (r[3:2] == 2'b00)) // mostly stay on the same page
			begin
				row  = pick_row(r[5:4]);
				bank = r[7:6];
			end
			col = COL_W'(r[10:8]);
			if (r[14:13] == 2'b11)
				bus_idle(6); // long enough for the idle close
			wb_access(r[12], {row, bank, col}, $random(seed));
		end
		bus_idle(20);
		@(posedge CLK);

		if (ack_count != NUM_ACC)
		begin
			bus_errors++;
			$display("ERROR: %0d acks seen for %0d accesses", ack_count, NUM_ACC);
		end
		if (cycle_cnt - last_arsr > REFRESH_LIMIT)
		begin
			sdram_errors++;
			$display("ERROR: no refresh in the last %0d cycles", cycle_cnt - last_arsr);
		end

		$display("errors: %0d mismatch, %0d sdram protocol, %0d bus",
			mismatch_errors, sdram_errors, bus_errors);
		if ((mismatch_errors + sdram_errors + bus_errors) == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== compile.f ====
hdl/sdram_pkg.sv
hdl/wb_request_port.sv
hdl/page_tracker.sv
hdl/command_timer.sv
hdl/sdram_pins.sv
hdl/sdram_ctrl_top.sv
tests/sdram_ctrl_properties.sv
tests/tb_sdram_ctrl.sv

// ==== Bender.yml ====
package:
  name: sdram_ctrl

sources:
  - files:
      - hdl/sdram_pkg.sv
      - hdl/wb_request_port.sv
      - hdl/page_tracker.sv
      - hdl/command_timer.sv
      - hdl/sdram_pins.sv
      - hdl/sdram_ctrl_top.sv

  - target: test
    files:
      - tests/sdram_ctrl_properties.sv
      - tests/tb_sdram_ctrl.sv
